// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_div_unit
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+hdl
hdl/div_op_pkg.sv
hdl/div_ctrl_pkg.sv
hdl/key_select_mux.sv
hdl/div_special_case.sv
hdl/iter_divider.sv
hdl/div_unit.sv
testbench/div_unit_properties.sv
testbench/tb_div_unit.sv

// ==== hdl/div_ctrl_pkg.sv ====
// control sequencing types of the iterative divider, shared with the protocol checks
`default_nettype none

package div_ctrl_pkg;

  // ========================================
  // divider FSM states
  // ========================================
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0, // waiting for div_valid_i
    ST_ITER = 2'd1, // shift-subtract loop running
    ST_DONE = 2'd2  // result held until consumed
  } div_state_e;

  // encoding 2'd3 unused, FSM falls back to idle

endpackage

`default_nettype wire

// ==== hdl/div_macros.svh ====
// width constants for the divide unit, included by the packages, RTL and testbench
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand and result width
`define DIV_XLEN 64

// one-hot operation code width
`define DIV_OP_W 8

// iteration counter, must hold DIV_XLEN
`define DIV_CNT_W 7

`endif

// ==== hdl/div_op_pkg.sv ====
// operation code and special-case result types shared by the divide unit blocks
`default_nettype none

`include "div_macros.svh"

package div_op_pkg;

  // ========================================
  // one-hot operation code
  // ========================================
  // word forms end in W and work on the low 32 bits only
  typedef enum logic [`DIV_OP_W-1:0] {
    OP_NONE = 8'b0000_0000, // no op, also tags a special result
    REM     = 8'b1000_0000, // signed remainder
    REMU    = 8'b0100_0000, // unsigned remainder
    REMUW   = 8'b0010_0000, // unsigned remainder, word
    REMW    = 8'b0001_0000, // signed remainder, word
    DIV     = 8'b0000_1000, // signed quotient
    DIVU    = 8'b0000_0100, // unsigned quotient
    DIVUW   = 8'b0000_0010, // unsigned quotient, word
    DIVW    = 8'b0000_0001  // signed quotient, word
  } div_op_e;

  // ========================================
  // special-case result
  // ========================================
  // hit set for divide by zero or signed overflow
  typedef struct packed {
    logic                 hit;   // loop is skipped
    logic [`DIV_XLEN-1:0] value; // final result, already sign-extended
  } special_res_t;

endpackage

`default_nettype wire

// ==== hdl/div_special_case.sv ====
// detects divide by zero and signed overflow and gives the RISC-V defined result for each op
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module div_special_case (
  input  div_op_pkg::div_op_e      div_op_i,
  input  logic [`DIV_XLEN-1:0]     dividend_i,
  input  logic [`DIV_XLEN-1:0]     divisor_i,
  output div_op_pkg::special_res_t special_o
);

  // ========================================
  // condition detection
  // ========================================
  logic                 zero_64;
  logic                 zero_32;
  logic                 ovf_64;
  logic                 ovf_32;
  logic [`DIV_XLEN-1:0] dividend_sext32;
  logic [`DIV_XLEN-1:0] all_ones;

  assign zero_64 = ~|divisor_i;
  assign zero_32 = ~|divisor_i[31:0]; // word ops ignore the upper half

  // most negative value divided by -1
  assign ovf_64 = (dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (&divisor_i);
  assign ovf_32 = (dividend_i[31:0] == 32'h8000_0000) && (&divisor_i[31:0]);

  assign dividend_sext32 = {{(`DIV_XLEN-32){dividend_i[31]}}, dividend_i[31:0]};
  assign all_ones        = {`DIV_XLEN{1'b1}};

  // ========================================
  // per-op records
  // ========================================
  div_op_pkg::special_res_t rem_r;
  div_op_pkg::special_res_t remu_r;
  div_op_pkg::special_res_t remuw_r;
  div_op_pkg::special_res_t remw_r;
  div_op_pkg::special_res_t div_r;
  div_op_pkg::special_res_t divu_r;
  div_op_pkg::special_res_t divuw_r;
  div_op_pkg::special_res_t divw_r;
  div_op_pkg::special_res_t no_hit;

  // remainder: dividend on zero divisor, zero on overflow
  assign rem_r   = '{hit: zero_64 | ovf_64, value: zero_64 ? dividend_i : '0};
  assign remu_r  = '{hit: zero_64, value: dividend_i};
  assign remuw_r = '{hit: zero_32, value: dividend_sext32};
  assign remw_r  = '{hit: zero_32 | ovf_32, value: zero_32 ? dividend_sext32 : '0};

  // quotient: all ones on zero divisor, dividend on overflow
  assign div_r   = '{hit: zero_64 | ovf_64, value: zero_64 ? all_ones : dividend_i};
  assign divu_r  = '{hit: zero_64, value: all_ones};
  assign divuw_r = '{hit: zero_32, value: all_ones};
  assign divw_r  = '{hit: zero_32 | ovf_32, value: zero_32 ? all_ones : dividend_sext32};

  assign no_hit = '{hit: 1'b0, value: '0}; // OP_NONE or unknown code

  key_select_mux #(
    .NR_KEY  (8),
    .KEY_LEN (`DIV_OP_W),
    .data_t  (div_op_pkg::special_res_t)
  ) i_special_mux (
    .key_i     (div_op_i),
    .default_i (no_hit),
    .lut_i     ({div_op_pkg::REM,   rem_r,
                 div_op_pkg::REMU,  remu_r,
                 div_op_pkg::REMUW, remuw_r,
                 div_op_pkg::REMW,  remw_r,
                 div_op_pkg::DIV,   div_r,
                 div_op_pkg::DIVU,  divu_r,
                 div_op_pkg::DIVUW, divuw_r,
                 div_op_pkg::DIVW,  divw_r}),
    .out_o     (special_o)
  );

endmodule

`default_nettype wire

// ==== hdl/div_unit.sv ====
// top level of the RV64M divide unit, special-case checker feeding the iterative divider
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module div_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 div_valid_i,    // start strobe
  input  div_op_pkg::div_op_e  div_op_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  input  logic                 result_ready_i,
  output logic [`DIV_XLEN-1:0] div_out_o,
  output logic                 div_stall_o,    // busy
  output logic                 result_ok_o     // done
);

  div_op_pkg::special_res_t special;

  // ========================================
  // divide by zero and overflow check
  // ========================================
  div_special_case i_special (
    .div_op_i   (div_op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .special_o  (special)
  );

  // ========================================
  // iterative divider
  // ========================================
  iter_divider i_divider (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .special_i      (special),
    .result_ready_i (result_ready_i),
    .div_out_o      (div_out_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

endmodule

`default_nettype wire

// ==== hdl/iter_divider.sv ====
// restoring shift-subtract divider with control FSM, operand conditioning and result fix-up
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module iter_divider (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     div_valid_i,
  input  div_op_pkg::div_op_e      div_op_i,
  input  logic [`DIV_XLEN-1:0]     dividend_i,
  input  logic [`DIV_XLEN-1:0]     divisor_i,
  input  div_op_pkg::special_res_t special_i,
  input  logic                     result_ready_i,
  output logic [`DIV_XLEN-1:0]     div_out_o,
  output logic                     div_stall_o,
  output logic                     result_ok_o
);

  // ========================================
  // state and registers
  // ========================================
  div_ctrl_pkg::div_state_e state_q;
  div_ctrl_pkg::div_state_e state_d;
  logic [`DIV_CNT_W-1:0]    cnt_q;   // iterations left
  div_op_pkg::div_op_e      op_q;    // OP_NONE marks a special result
  logic [2*`DIV_XLEN-1:0]   rq_q;    // {remainder, quotient}
  logic [`DIV_XLEN-1:0]     dvs_q;   // absolute divisor
  logic                     q_neg_q;
  logic                     r_neg_q;

  logic accept;
  logic iter_step;

  assign accept    = (state_q == div_ctrl_pkg::ST_IDLE) && div_valid_i;
  assign iter_step = (state_q == div_ctrl_pkg::ST_ITER) && (cnt_q != '0);

  // ========================================
  // operand conditioning
  // ========================================
  logic                 op_word;
  logic                 op_signed;
  logic [`DIV_XLEN-1:0] dvd_ext;
  logic [`DIV_XLEN-1:0] dvs_ext;
  logic                 dvd_neg;
  logic                 dvs_neg;
  logic [`DIV_XLEN-1:0] dvd_abs;
  logic [`DIV_XLEN-1:0] dvs_abs;

  assign op_word   = div_op_i inside {div_op_pkg::REMUW, div_op_pkg::REMW,
                                      div_op_pkg::DIVUW, div_op_pkg::DIVW};
  assign op_signed = div_op_i inside {div_op_pkg::REM, div_op_pkg::REMW,
                                      div_op_pkg::DIV, div_op_pkg::DIVW};

  // word ops only see the low half, sign-extended
  assign dvd_ext = op_word ? {{(`DIV_XLEN-32){dividend_i[31]}}, dividend_i[31:0]} : dividend_i;
  assign dvs_ext = op_word ? {{(`DIV_XLEN-32){divisor_i[31]}}, divisor_i[31:0]} : divisor_i;

  assign dvd_neg = op_signed & dvd_ext[`DIV_XLEN-1];
  assign dvs_neg = op_signed & dvs_ext[`DIV_XLEN-1];

  assign dvd_abs = dvd_neg ? -dvd_ext : dvd_ext;
  assign dvs_abs = dvs_neg ? -dvs_ext : dvs_ext;

  // ========================================
  // iteration step
  // ========================================
  logic [`DIV_XLEN:0]     diff;    // 65 bits, msb is the borrow
  logic [2*`DIV_XLEN-1:0] rq_step;

  // shifted partial remainder minus divisor
  assign diff = rq_q[2*`DIV_XLEN-1:`DIV_XLEN-1] - {1'b0, dvs_q};

  assign rq_step = diff[`DIV_XLEN] ? {rq_q[2*`DIV_XLEN-2:0], 1'b0} :
                                     {diff[`DIV_XLEN-1:0], rq_q[`DIV_XLEN-2:0], 1'b1};

  // ========================================
  // control FSM
  // ========================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      div_ctrl_pkg::ST_IDLE: begin
        if (div_valid_i) begin
          state_d = special_i.hit ? div_ctrl_pkg::ST_DONE : div_ctrl_pkg::ST_ITER;
        end
      end
      div_ctrl_pkg::ST_ITER: begin
        if (cnt_q == '0) begin
          state_d = div_ctrl_pkg::ST_DONE; // terminal-count cycle
        end
      end
      div_ctrl_pkg::ST_DONE: begin
        if (result_ready_i) begin
          state_d = div_ctrl_pkg::ST_IDLE;
        end
      end
      default: state_d = div_ctrl_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= div_ctrl_pkg::ST_IDLE;
      cnt_q   <= '0;
      op_q    <= div_op_pkg::OP_NONE;
    end else begin
      state_q <= state_d;
      if (accept) begin
        op_q  <= special_i.hit ? div_op_pkg::OP_NONE : div_op_i;
        cnt_q <= op_word ? `DIV_CNT_W'(`DIV_XLEN/2) : `DIV_CNT_W'(`DIV_XLEN);
      end else if (iter_step) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (accept) begin
      if (special_i.hit) begin
        rq_q <= {{`DIV_XLEN{1'b0}}, special_i.value}; // passed straight out
      end else begin
        // word dividend pre-shifted so 32 steps finish it
        rq_q <= {{`DIV_XLEN{1'b0}},
                 op_word ? {dvd_abs[31:0], 32'b0} : dvd_abs};
      end
      dvs_q   <= op_word ? {32'b0, dvs_abs[31:0]} : dvs_abs;
      q_neg_q <= dvd_neg ^ dvs_neg;
      r_neg_q <= dvd_neg; // remainder follows the dividend
    end else if (iter_step) begin
      rq_q <= rq_step;
    end
  end

  // ========================================
  // result selection
  // ========================================
  logic [`DIV_XLEN-1:0] quot_fix;
  logic [`DIV_XLEN-1:0] rem_fix;
  logic [`DIV_XLEN-1:0] quot_w;
  logic [`DIV_XLEN-1:0] rem_w;

  assign quot_fix = q_neg_q ? -rq_q[`DIV_XLEN-1:0] : rq_q[`DIV_XLEN-1:0];
  assign rem_fix  = r_neg_q ? -rq_q[2*`DIV_XLEN-1:`DIV_XLEN] : rq_q[2*`DIV_XLEN-1:`DIV_XLEN];

  assign quot_w = {{(`DIV_XLEN-32){quot_fix[31]}}, quot_fix[31:0]};
  assign rem_w  = {{(`DIV_XLEN-32){rem_fix[31]}}, rem_fix[31:0]};

  // unsigned ops carry clear sign flags, so the fixed values serve them too
  key_select_mux #(
    .NR_KEY  (8),
    .KEY_LEN (`DIV_OP_W),
    .data_t  (logic [`DIV_XLEN-1:0])
  ) i_result_mux (
    .key_i     (op_q),
    .default_i (rq_q[`DIV_XLEN-1:0]), // special value
    .lut_i     ({div_op_pkg::REM,   rem_fix,
                 div_op_pkg::REMU,  rem_fix,
                 div_op_pkg::REMUW, rem_w,
                 div_op_pkg::REMW,  rem_w,
                 div_op_pkg::DIV,   quot_fix,
                 div_op_pkg::DIVU,  quot_fix,
                 div_op_pkg::DIVUW, quot_w,
                 div_op_pkg::DIVW,  quot_w}),
    .out_o     (div_out_o)
  );

  assign result_ok_o = (state_q == div_ctrl_pkg::ST_DONE);

  // hold the pipeline from the accepting cycle on
  assign div_stall_o = (accept && !special_i.hit) || (state_q == div_ctrl_pkg::ST_ITER);

endmodule

`default_nettype wire

// ==== hdl/key_select_mux.sv ====
// combinational key-matched lookup mux with a generic payload type and a default output
`timescale 1ns/1ps
`default_nettype none

module key_select_mux #(
  parameter int  NR_KEY  = 2,           // number of lookup entries
  parameter int  KEY_LEN = 1,           // key width
  parameter type data_t  = logic [31:0] // payload type
) (
  input  logic [KEY_LEN-1:0]                           key_i,
  input  data_t                                        default_i,
  input  logic [NR_KEY-1:0][KEY_LEN+$bits(data_t)-1:0] lut_i,     // {key, payload} pairs
  output data_t                                        out_o
);

  localparam int DATA_W = $bits(data_t);

  // keys are expected to be unique, so the scan order does not matter
  always_comb begin
    out_o = default_i;
    for (int i = 0; i < NR_KEY; i++) begin
      // key sits above the payload in every entry
      if (lut_i[i][DATA_W +: KEY_LEN] == key_i) begin
        out_o = data_t'(lut_i[i][DATA_W-1:0]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/div_input_vectors.txt ====
# columns: op code, dividend, divisor, expected result (all hex)
80 0000000000000064 0000000000000007 0000000000000002
08 0000000000000064 0000000000000007 000000000000000e
08 ffffffffffffff9c 0000000000000007 fffffffffffffff2
08 0000000000000064 fffffffffffffff9 fffffffffffffff2
08 ffffffffffffff9c fffffffffffffff9 000000000000000e
80 ffffffffffffff9c 0000000000000007 fffffffffffffffe
80 0000000000000064 fffffffffffffff9 0000000000000002
80 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
08 8000000000000000 0000000000000002 c000000000000000
04 ffffffffffffffff 000000000000000a 1999999999999999
40 ffffffffffffffff 000000000000000a 0000000000000005
04 ffffffffffffff9c 0000000000000007 2492492492492484
01 deadbeefffffff9c 1234567800000007 fffffffffffffff2
10 deadbeefffffff9c 1234567800000007 fffffffffffffffe
02 fffffffffffffff0 abcdef0100000010 000000000fffffff
02 0000000180000000 0000000000000001 ffffffff80000000
20 00000000fffffffe 00000000ffffffff fffffffffffffffe
08 0000000000000064 0000000000000000 ffffffffffffffff
04 123456789abcdef0 0000000000000000 ffffffffffffffff
02 00000000000000ff ffffffff00000000 ffffffffffffffff
01 ffffffffffffff9c 0000000000000000 ffffffffffffffff
80 ffffffffffffff9c 0000000000000000 ffffffffffffff9c
40 123456789abcdef0 0000000000000000 123456789abcdef0
20 1234567880000001 abcd000000000000 ffffffff80000001
10 0000000012345678 0000000000000000 0000000012345678
08 8000000000000000 ffffffffffffffff 8000000000000000
80 8000000000000000 ffffffffffffffff 0000000000000000
01 0000000080000000 00000000ffffffff ffffffff80000000
10 1111111180000000 22222222ffffffff 0000000000000000

// ==== testbench/div_unit_properties.sv ====
// protocol assertions on the divider FSM and result strobes, bound into iter_divider
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module div_unit_properties (
  input logic                     clk,
  input logic                     rst_n,
  input div_ctrl_pkg::div_state_e state_i,
  input logic                     result_ready_i,
  input logic [`DIV_XLEN-1:0]     div_out_i,
  input logic                     div_stall_i,
  input logic                     result_ok_i
);

  // done and busy never overlap
  ok_not_with_stall: assert property (
    @(posedge clk) disable iff (rst_n) !(result_ok_i && div_stall_i)
  ) else $error("result_ok_o and div_stall_o high in the same cycle");

  // back-pressure holds the result
  ok_held_until_ready: assert property (
    @(posedge clk) disable iff (rst_n)
    (result_ok_i && !result_ready_i) |=> (result_ok_i && $stable(div_out_i))
  ) else $error("result_ok_o dropped or div_out_o changed before result_ready_i");

  ok_iter_exits_to_done: assert property (
    @(posedge clk) disable iff (rst_n)
    (state_i == div_ctrl_pkg::ST_ITER) |=>
      (state_i == div_ctrl_pkg::ST_ITER || state_i == div_ctrl_pkg::ST_DONE)
  ) else $error("divider left ST_ITER for a state other than ST_DONE");

endmodule

bind iter_divider div_unit_properties i_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .state_i        (state_q),
  .result_ready_i (result_ready_i),
  .div_out_i      (div_out_o),
  .div_stall_i    (div_stall_o),
  .result_ok_i    (result_ok_o)
);

`default_nettype wire

// ==== testbench/tb_div_unit.sv ====
// self-checking testbench for the divide unit, replays the vector file and checks results
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module tb_div_unit;

  localparam int TIMEOUT_CYCLES = 200;

  logic                 clk;
  logic                 rst_n;
  logic                 div_valid_i;
  div_op_pkg::div_op_e  div_op_i;
  logic [`DIV_XLEN-1:0] dividend_i;
  logic [`DIV_XLEN-1:0] divisor_i;
  logic                 result_ready_i;
  logic [`DIV_XLEN-1:0] div_out_o;
  logic                 div_stall_o;
  logic                 result_ok_o;

  int          errors;
  int          checks;
  int          results;   // rises of result_ok_o
  bit          timed_out;
  logic [31:0] lcg_state;
  logic        ok_prev;

  div_unit i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .div_out_o      (div_out_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  always #5 clk = ~clk;

  // a stray accept would show up as an extra rise of result_ok_o
  always @(posedge clk) begin
    ok_prev <= result_ok_o;
    if (!rst_n && result_ok_o && !ok_prev) begin
      results <= results + 1;
    end
  end

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // edges from acceptance until result_ok_o is seen (none for the special cases)
  function automatic int expected_latency(input logic [7:0] op, input logic [63:0] a,
                                          input logic [63:0] b);
    logic word;
    logic sgn;
    logic special;
    word = (op == 8'h20) || (op == 8'h10) || (op == 8'h02) || (op == 8'h01);
    sgn  = (op == 8'h80) || (op == 8'h10) || (op == 8'h08) || (op == 8'h01);
    if (word) begin
      special = (b[31:0] == 32'h0) ||
                (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff);
    end else begin
      special = (b == 64'h0) || (sgn && a == {1'b1, 63'h0} && b == {64{1'b1}});
    end
    if (special) begin
      return 0;
    end
    return word ? 33 : 65;
  endfunction

  task automatic check_value(input string name, input logic [`DIV_XLEN-1:0] exp,
                             input logic [`DIV_XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // one request is entered and left 1 ns after a rising edge
  task automatic run_vector(input int idx, input logic [7:0] op, input logic [63:0] a,
                            input logic [63:0] b, input logic [63:0] exp);
    div_op_pkg::div_op_e op_e;
    string               name;
    int                  latency;
    int                  cycles;
    int                  delay;
    op_e    = div_op_pkg::div_op_e'(op);
    name    = $sformatf("vec%0d_%s", idx, op_e.name());
    latency = expected_latency(op, a, b);
    div_valid_i = 1'b1;
    div_op_i    = op_e;
    dividend_i  = a;
    divisor_i   = b;
    #1;
    check_value({name, "_stall_at_accept"}, 64'(latency != 0), 64'(div_stall_o));
    @(posedge clk);
    #1;
    div_valid_i = 1'b0;
    cycles      = 0;
    while (!result_ok_o && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
      div_valid_i = (cycles == 2); // stray request while busy
      div_op_i    = div_op_pkg::DIV;
      divisor_i   = '0;
    end
    div_valid_i = 1'b0;
    if (!result_ok_o) begin
      $display("timeout: %s got no result_ok_o within %0d cycles", name, TIMEOUT_CYCLES);
      errors++;
      timed_out = 1'b1;
    end else begin
      check_count({name, "_latency"}, latency, cycles);
      lcg_state = lcg_next(lcg_state);
      delay     = int'(lcg_state[18:16]);
      for (int i = 0; i < delay; i++) begin
        check_value({name, "_ok_held"}, 64'h1, 64'(result_ok_o));
        check_value({name, "_held"}, exp, div_out_o);
        div_valid_i = (i == 0); // ignored while done
        @(posedge clk);
        #1;
      end
      div_valid_i = 1'b0;
      check_value({name, "_ok_held"}, 64'h1, 64'(result_ok_o));
      check_value(name, exp, div_out_o);
      result_ready_i = 1'b1;
      @(posedge clk);
      #1;
      result_ready_i = 1'b0;
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    int          fd;
    int          idx;
    string       line;
    logic [7:0]  op_val;
    logic [63:0] a_val;
    logic [63:0] b_val;
    logic [63:0] exp_val;
    clk            = 1'b0;
    rst_n          = 1'b1; // reset is active high
    div_valid_i    = 1'b0;
    div_op_i       = div_op_pkg::OP_NONE;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    errors         = 0;
    checks         = 0;
    results        = 0;
    timed_out      = 1'b0;
    ok_prev        = 1'b0;
    lcg_state      = 32'h1cb4847e;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b0;
    check_value("reset_result_ok", 64'h0, 64'(result_ok_o));
    check_value("reset_stall", 64'h0, 64'(div_stall_o));
    fd = $fopen("testbench/div_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file testbench/div_input_vectors.txt");
      errors++;
    end else begin
      idx = 0;
      while (!timed_out && $fgets(line, fd) != 0) begin
        // comment lines fail the scan and are skipped
        if ($sscanf(line, "%h %h %h %h", op_val, a_val, b_val, exp_val) == 4) begin
          run_vector(idx, op_val, a_val, b_val, exp_val);
          idx++;
        end
      end
      $fclose(fd);
      if (!timed_out) begin
        check_count("result_count", idx, results);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
